// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_int_exec
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/dec_ex_if.sv ====
`timescale 1ns/1ns

interface dec_ex_if #(
	parameter int xlen = rv_pkg::XLEN
);

	logic                 valid;	// one-cycle pulse per item
	rv_pkg::alu_op_t      alu_op;
	rv_pkg::src_sel_t     src_sel;
	rv_pkg::inst_class_t  inst_class;
	logic [2:0]           funct3;	// branch condition
	logic [4:0]           rs1;
	logic [4:0]           rs2;
	logic [4:0]           rd;	// zero for classes with no write
	logic [xlen-1:0]      imm;
	logic [xlen-1:0]      pc;

	modport src (
		output valid, alu_op, src_sel, inst_class, funct3, rs1, rs2, rd, imm, pc
	);

	modport dst (
		input valid, alu_op, src_sel, inst_class, funct3, rs1, rs2, rd, imm, pc
	);

endinterface

// ==== common/ex_wb_if.sv ====
`timescale 1ns/1ns

interface ex_wb_if #(
	parameter int xlen = rv_pkg::XLEN
);

	logic            valid;
	logic            wb_en;	// write rd at writeback
	logic [4:0]      rd;
	logic [xlen-1:0] data;
	logic            br_taken;
	logic [xlen-1:0] br_target;

	// src reads back its own copy for the bypass
	modport src (
		output valid, wb_en, rd, data, br_taken, br_target
	);

	modport dst (
		input valid, wb_en, rd, data, br_taken, br_target
	);

endinterface

// ==== common/rv_pkg.sv ====
package rv_pkg;

	// data and address width, default for every xlen parameter
	parameter int XLEN = 32;

	// alu operations
	typedef enum logic [3:0] {
		ALU_NONE = 4'd0,
		ALU_ADD  = 4'd1,
		ALU_SUB  = 4'd2,
		ALU_SLL  = 4'd3,
		ALU_SLT  = 4'd4,
		ALU_SLTU = 4'd5,
		ALU_XOR  = 4'd6,
		ALU_SRL  = 4'd7,
		ALU_SRA  = 4'd8,
		ALU_OR   = 4'd9,
		ALU_AND  = 4'd10,
		ALU_PC   = 4'd11	// a + b for pc-relative results
	} alu_op_t;

	// operand source pairs, first is operand a
	typedef enum logic [1:0] {
		SRC_RS1_IMM = 2'd0,
		SRC_RS1_RS2 = 2'd1,
		SRC_PC_IMM  = 2'd2,
		SRC_PC_4    = 2'd3
	} src_sel_t;

	// instruction class, drives writeback and branch handling
	typedef enum logic [2:0] {
		CLS_ALU    = 3'd0,
		CLS_BRANCH = 3'd1,
		CLS_JAL    = 3'd2,
		CLS_JALR   = 3'd3,
		CLS_NOWB   = 3'd4	// load, store, fence, system, illegal
	} inst_class_t;

	// major opcode groups
	localparam logic [6:0] OPC_LUI    = 7'b0110111;	// lui
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;	// auipc
	localparam logic [6:0] OPC_JAL    = 7'b1101111;	// jal
	localparam logic [6:0] OPC_JALR   = 7'b1100111;	// jalr
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;	// beq .. bgeu
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;	// lb .. lhu
	localparam logic [6:0] OPC_STORE  = 7'b0100011;	// sb, sh, sw
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;	// addi .. srai
	localparam logic [6:0] OPC_OP     = 7'b0110011;	// add .. and
	localparam logic [6:0] OPC_FENCE  = 7'b0001111;	// fence, fence.i
	localparam logic [6:0] OPC_SYS    = 7'b1110011;	// ecall, ebreak, csr

endpackage

// ==== decode/inst_decode.sv ====
`timescale 1ns/1ns

module inst_decode #(
	parameter int xlen = rv_pkg::XLEN
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            inst_valid,
	input  logic [31:0]     inst,
	input  logic [xlen-1:0] pc,
	dec_ex_if.src           dec
);

	logic [6:0]          opcode;
	logic [xlen-1:0]     imm_i;
	logic [xlen-1:0]     imm_s;
	logic [xlen-1:0]     imm_b;
	logic [xlen-1:0]     imm_u;
	logic [xlen-1:0]     imm_j;
	logic [xlen-1:0]     imm;
	logic [4:0]          rs1;
	logic [4:0]          rd;
	rv_pkg::alu_op_t     alu_op;
	rv_pkg::src_sel_t    src_sel;
	rv_pkg::inst_class_t inst_class;

	assign opcode = inst[6:0];

	// sign-extended immediates
	assign imm_i = {{(xlen-11){inst[31]}}, inst[30:20]};
	assign imm_s = {{(xlen-11){inst[31]}}, inst[30:25], inst[11:7]};
	assign imm_b = {{(xlen-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {{(xlen-31){inst[31]}}, inst[30:12], 12'b0};
	assign imm_j = {{(xlen-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		case (opcode)
			rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: imm = imm_u;
			rv_pkg::OPC_JAL                   : imm = imm_j;
			rv_pkg::OPC_BRANCH                : imm = imm_b;
			rv_pkg::OPC_STORE                 : imm = imm_s;
			default                           : imm = imm_i;
		endcase
	end

	op_select u_op_select (
		.opcode     (opcode),
		.funct3     (inst[14:12]),
		.funct7_5   (inst[30]),
		.alu_op     (alu_op),
		.src_sel    (src_sel),
		.inst_class (inst_class)
	);

	assign rs1 = (opcode == rv_pkg::OPC_LUI) ? 5'd0 : inst[19:15];	// lui adds to x0
	assign rd  = (inst_class == rv_pkg::CLS_BRANCH || inst_class == rv_pkg::CLS_NOWB) ?
	             5'd0 : inst[11:7];

	always_ff @(posedge clk) begin
		if (rst) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= inst_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid) begin	// payload held while idle
			dec.alu_op     <= alu_op;
			dec.src_sel    <= src_sel;
			dec.inst_class <= inst_class;
			dec.funct3     <= inst[14:12];
			dec.rs1        <= rs1;
			dec.rs2        <= inst[24:20];
			dec.rd         <= rd;
			dec.imm        <= imm;
			dec.pc         <= pc;
		end
	end

endmodule

// ==== decode/op_select.sv ====
`timescale 1ns/1ns

module op_select (
	input  logic [6:0]          opcode,
	input  logic [2:0]          funct3,
	input  logic                funct7_5,	// inst bit 30
	output rv_pkg::alu_op_t     alu_op,
	output rv_pkg::src_sel_t    src_sel,
	output rv_pkg::inst_class_t inst_class
);

	always_comb begin
		alu_op = rv_pkg::ALU_NONE;
		case (opcode)
			rv_pkg::OPC_LUI   : alu_op = rv_pkg::ALU_ADD;	// x0 + imm
			rv_pkg::OPC_AUIPC : alu_op = rv_pkg::ALU_PC;
			rv_pkg::OPC_JAL   : alu_op = rv_pkg::ALU_PC;	// link = pc + 4
			rv_pkg::OPC_JALR  : alu_op = rv_pkg::ALU_PC;
			rv_pkg::OPC_BRANCH: begin
				case (funct3)
					3'b000, 3'b001: alu_op = rv_pkg::ALU_SUB;	// beq, bne
					3'b100, 3'b101: alu_op = rv_pkg::ALU_SLT;	// blt, bge
					3'b110, 3'b111: alu_op = rv_pkg::ALU_SLTU;	// bltu, bgeu
					default       : alu_op = rv_pkg::ALU_NONE;
				endcase
			end
			rv_pkg::OPC_OP_IMM: begin
				case (funct3)
					3'b000 : alu_op = rv_pkg::ALU_ADD;	// addi, no subi
					3'b001 : alu_op = rv_pkg::ALU_SLL;
					3'b010 : alu_op = rv_pkg::ALU_SLT;	// signed slti
					3'b011 : alu_op = rv_pkg::ALU_SLTU;
					3'b100 : alu_op = rv_pkg::ALU_XOR;
					3'b101 : alu_op = funct7_5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
					3'b110 : alu_op = rv_pkg::ALU_OR;
					default: alu_op = rv_pkg::ALU_AND;
				endcase
			end
			rv_pkg::OPC_OP    : begin
				case (funct3)
					3'b000 : alu_op = funct7_5 ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
					3'b001 : alu_op = rv_pkg::ALU_SLL;
					3'b010 : alu_op = rv_pkg::ALU_SLT;
					3'b011 : alu_op = rv_pkg::ALU_SLTU;
					3'b100 : alu_op = rv_pkg::ALU_XOR;
					3'b101 : alu_op = funct7_5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
					3'b110 : alu_op = rv_pkg::ALU_OR;
					default: alu_op = rv_pkg::ALU_AND;
				endcase
			end
			// address-style rs1 + imm, result unused downstream
			rv_pkg::OPC_LOAD, rv_pkg::OPC_STORE,
			rv_pkg::OPC_FENCE, rv_pkg::OPC_SYS: alu_op = rv_pkg::ALU_ADD;
			default: alu_op = rv_pkg::ALU_NONE;
		endcase
	end

	always_comb begin
		src_sel    = rv_pkg::SRC_RS1_IMM;	// lui, load, store, op_imm, misc
		inst_class = rv_pkg::CLS_NOWB;
		case (opcode)
			rv_pkg::OPC_LUI   : inst_class = rv_pkg::CLS_ALU;
			rv_pkg::OPC_OP_IMM: inst_class = rv_pkg::CLS_ALU;
			rv_pkg::OPC_AUIPC : begin
				src_sel    = rv_pkg::SRC_PC_IMM;
				inst_class = rv_pkg::CLS_ALU;
			end
			rv_pkg::OPC_JAL   : begin
				src_sel    = rv_pkg::SRC_PC_4;
				inst_class = rv_pkg::CLS_JAL;
			end
			rv_pkg::OPC_JALR  : begin
				src_sel    = rv_pkg::SRC_PC_4;
				inst_class = rv_pkg::CLS_JALR;
			end
			rv_pkg::OPC_BRANCH: begin
				src_sel    = rv_pkg::SRC_RS1_RS2;
				inst_class = rv_pkg::CLS_BRANCH;
			end
			rv_pkg::OPC_OP    : begin
				src_sel    = rv_pkg::SRC_RS1_RS2;
				inst_class = rv_pkg::CLS_ALU;
			end
			default: inst_class = rv_pkg::CLS_NOWB;
		endcase
	end

endmodule

// ==== dv/int_exec_sva.sv ====
`timescale 1ns/1ns

module int_exec_sva (
	input logic clk,
	input logic rst,
	input logic exr_valid,
	input logic wb_valid,
	input logic br_taken
);

	wb_idle_after_reset: assert property (@(posedge clk) rst |=> !wb_valid)
		else $error("wb_valid high in the cycle after reset");

	// one register stage between execute and the ports
	wb_follows_exr: assert property (@(posedge clk) disable iff (rst)
		wb_valid == $past(exr_valid))
		else $error("wb_valid does not follow exr.valid by one cycle");

	taken_needs_valid: assert property (@(posedge clk) disable iff (rst)
		br_taken |-> wb_valid)
		else $error("br_taken high without wb_valid");

endmodule

bind writeback int_exec_sva u_sva (
	.clk       (clk),
	.rst       (rst),
	.exr_valid (exr.valid),
	.wb_valid  (wb_valid),
	.br_taken  (br_taken)
);

// ==== dv/tb_int_exec.sv ====
`timescale 1ns/1ns

module tb_int_exec;

	localparam int xlen    = rv_pkg::XLEN;
	localparam int n_insts = 2 + 33 + 28 + 90 + 7 + 6;	// issue slots per test, in order
	localparam int n_tsts  = 6;
	localparam int wd_ns   = (n_insts + 8 * n_tsts + 20) * 100;	// drain slack per test

	typedef struct packed {
		logic [31:0]     due;	// edge count when the result shows
		logic [4:0]      rd;
		logic [xlen-1:0] data;
		logic            taken;
		logic [xlen-1:0] target;
	} exp_t;

	logic            clk;
	logic            rst;
	logic            inst_valid;
	logic [31:0]     inst;
	logic [xlen-1:0] pc;
	logic            wb_valid;
	logic [4:0]      wb_rd;
	logic [xlen-1:0] wb_data;
	logic            br_taken;
	logic [xlen-1:0] br_target;

	logic [xlen-1:0] sh [32];	// architectural state in issue order
	exp_t            exp_q [$];
	logic [31:0]     edge_cnt;
	logic [xlen-1:0] cur_pc;
	int              err_cnt;
	int              err_mark;
	int              chk_cnt;
	int              tst_cnt;

	int_exec_unit #(.xlen(xlen)) UUT (
		.clk        (clk),
		.rst        (rst),
		.inst_valid (inst_valid),
		.inst       (inst),
		.pc         (pc),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.br_taken   (br_taken),
		.br_target  (br_target)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) edge_cnt <= edge_cnt + 1;

	initial begin
		#(wd_ns);
		$display("watchdog expired after %0d ns, the tests did not finish", wd_ns);
		$display("TEST FAILED");
		$finish;
	end

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
	endfunction

	// integer op per the base ISA, reg selects sub from bit 30
	function automatic logic [xlen-1:0] alu_ref(input logic [2:0] f3, input logic b30,
			input logic is_reg, input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		case (f3)
			3'd0   : return (is_reg && b30) ? a - b : a + b;
			3'd1   : return a << b[4:0];
			3'd2   : return xlen'($signed(a) < $signed(b));
			3'd3   : return xlen'(a < b);
			3'd4   : return a ^ b;
			3'd5   : return b30 ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6   : return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic exp_t predict(input logic [31:0] ins, input logic [xlen-1:0] ipc);
		exp_t            e;
		logic            wr;
		logic [xlen-1:0] val;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] imm_i;
		logic [xlen-1:0] imm_b;
		logic [xlen-1:0] imm_u;
		logic [xlen-1:0] imm_j;
		a     = sh[ins[19:15]];
		b     = sh[ins[24:20]];
		imm_i = xlen'($signed(ins[31:20]));
		imm_b = xlen'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
		imm_u = xlen'($signed({ins[31:12], 12'b0}));
		imm_j = xlen'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
		e     = '0;
		wr    = 1'b0;
		val   = '0;
		case (ins[6:0])
			rv_pkg::OPC_LUI   : begin
				wr  = 1'b1;
				val = imm_u;
			end
			rv_pkg::OPC_AUIPC : begin
				wr  = 1'b1;
				val = ipc + imm_u;
			end
			rv_pkg::OPC_OP_IMM: begin
				wr  = 1'b1;
				val = alu_ref(ins[14:12], ins[30], 1'b0, a, imm_i);
			end
			rv_pkg::OPC_OP    : begin
				wr  = 1'b1;
				val = alu_ref(ins[14:12], ins[30], 1'b1, a, b);
			end
			rv_pkg::OPC_JAL   : begin
				wr       = 1'b1;
				val      = ipc + 4;
				e.taken  = 1'b1;
				e.target = ipc + imm_j;
			end
			rv_pkg::OPC_JALR  : begin
				wr       = 1'b1;
				val      = ipc + 4;
				e.taken  = 1'b1;
				e.target = (a + imm_i) & ~xlen'(1);
			end
			rv_pkg::OPC_BRANCH: begin
				case (ins[14:12])
					3'd0   : e.taken = (a == b);
					3'd1   : e.taken = (a != b);
					3'd4   : e.taken = ($signed(a) < $signed(b));
					3'd5   : e.taken = ($signed(a) >= $signed(b));
					3'd6   : e.taken = (a < b);
					default: e.taken = (a >= b);
				endcase
				e.target = e.taken ? ipc + imm_b : '0;
			end
			default: wr = 1'b0;	// load, store, fence, system
		endcase
		if (wr && ins[11:7] != 5'd0) begin
			sh[ins[11:7]] = val;
			e.rd          = ins[11:7];
			e.data        = val;
		end
		return e;
	endfunction

	task automatic error_line(input string msg);
		$display("ERROR %0t ns: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic check_wb(input logic [4:0] rd_got, input logic [4:0] rd_exp,
			input logic [xlen-1:0] d_got, input logic [xlen-1:0] d_exp);
		chk_cnt++;
		if (rd_got !== rd_exp || d_got !== d_exp) begin
			error_line($sformatf("writeback x%0d = %h, expected x%0d = %h",
				rd_got, d_got, rd_exp, d_exp));
		end
	endtask

	task automatic check_branch(input logic tk_got, input logic tk_exp,
			input logic [xlen-1:0] tg_got, input logic [xlen-1:0] tg_exp);
		chk_cnt++;
		if (tk_got !== tk_exp || tg_got !== tg_exp) begin
			error_line($sformatf("branch taken %b target %h, expected %b target %h",
				tk_got, tg_got, tk_exp, tg_exp));
		end
	endtask

	// compare results in the stable half of the cycle
	always @(negedge clk) begin : monitor
		exp_t e;
		if (!rst) begin
			while (exp_q.size() > 0 && exp_q[0].due < edge_cnt) begin
				$display("missing result at %0t ns: no wb_valid for an issued item", $time);
				err_cnt++;
				void'(exp_q.pop_front());
			end
			if (wb_valid === 1'b1) begin
				if (exp_q.size() == 0 || exp_q[0].due != edge_cnt) begin
					$display("wb_valid at %0t ns with no instruction due", $time);
					err_cnt++;
				end else begin
					e = exp_q.pop_front();
					check_wb(wb_rd, e.rd, wb_data, e.data);
					check_branch(br_taken, e.taken, br_target, e.target);
				end
			end
		end
	end

	task automatic issue(input logic [31:0] ins);
		exp_t e;
		@(posedge clk);
		inst_valid <= 1'b1;
		inst       <= ins;
		pc         <= cur_pc;
		e          = predict(ins, cur_pc);
		e.due      = edge_cnt + 4;	// edge_cnt still holds the count before this edge
		exp_q.push_back(e);
		cur_pc     = cur_pc + 4;
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [xlen-1:0] val);
		logic [xlen-1:0] hi;
		hi = (val + 32'h800) >> 12;	// addi sign-extends the low part
		issue({hi[19:0], rd, rv_pkg::OPC_LUI});
		issue(i_type(val[11:0], rd, 3'd0, rd, rv_pkg::OPC_OP_IMM));
	endtask

	task automatic finish_test(input string name);
		@(posedge clk);
		inst_valid <= 1'b0;
		inst       <= '0;
		while (exp_q.size() != 0) @(negedge clk);
		tst_cnt++;
		$display("test %0d %s done, %0d errors", tst_cnt, name, err_cnt - err_mark);
		err_mark = err_cnt;
	endtask

	task automatic test_reset();
		@(negedge clk);
		if (wb_valid !== 1'b0) begin
			error_line("wb_valid not low after reset");
		end
		check_branch(br_taken, 1'b0, br_target, '0);
		issue(r_type(7'd0, 5'd0, 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OP));	// add x1, x0, x0
		issue(r_type(7'd0, 5'd0, 5'd0, 3'd0, 5'd0, rv_pkg::OPC_OP));
		finish_test("reset");
	endtask

	task automatic test_op_imm();
		logic [11:0] imm;
		logic [4:0]  src;
		for (int r = 1; r < 8; r++) begin
			issue(i_type(12'($urandom), 5'd0, 3'd0, 5'(r), rv_pkg::OPC_OP_IMM));
		end
		load_const(5'd8, $urandom | 32'h8000_0000);	// negative for signed compares
		load_const(5'd9, $urandom);
		for (int s = 0; s < 2; s++) begin
			src = s ? 5'd1 : 5'd8;
			for (int f = 0; f < 9; f++) begin
				imm = 12'($urandom);
				if (f == 1 || f == 5) imm = {7'd0, imm[4:0]};
				if (f == 8) imm = {7'b0100000, imm[4:0]};	// srai
				issue(i_type(imm, src, (f == 8) ? 3'd5 : 3'(f), 5'(10 + f),
					rv_pkg::OPC_OP_IMM));
			end
		end
		issue(i_type(12'h001, 5'd8, 3'd2, 5'd20, rv_pkg::OPC_OP_IMM));	// slti x8, 1
		issue(i_type(12'h001, 5'd8, 3'd3, 5'd21, rv_pkg::OPC_OP_IMM));	// sltiu x8, 1
		issue({20'($urandom), 5'd22, rv_pkg::OPC_AUIPC});
		issue({20'($urandom), 5'd23, rv_pkg::OPC_LUI});
		finish_test("op_imm");
	endtask

	task automatic test_op_reg();
		logic [2:0] f3s [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
		logic       b30 [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
		for (int rnd = 0; rnd < 2; rnd++) begin
			load_const(5'd8, $urandom);
			load_const(5'd9, $urandom);
			for (int i = 0; i < 10; i++) begin	// rs1 from bypass, rs2 two ahead
				issue(r_type(b30[i] ? 7'b0100000 : 7'd0, 5'(8 + i), 5'(9 + i), f3s[i],
					5'(10 + i), rv_pkg::OPC_OP));
			end
		end
		finish_test("op_reg");
	endtask

	task automatic test_branch();
		logic [2:0]      conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		logic [xlen-1:0] a;
		logic [xlen-1:0] d;
		for (int c = 0; c < 6; c++) begin
			for (int k = 0; k < 3; k++) begin	// equal, less, greater
				a = $urandom;
				d = ($urandom % 1000) + 1;
				load_const(5'd20, a);
				load_const(5'd21, (k == 0) ? a : (k == 1) ? a + d : a - d);
				issue(b_type(13'($urandom) & ~13'd1, 5'd21, 5'd20, conds[c]));
			end
		end
		finish_test("branch");
	endtask

	task automatic test_jump();
		load_const(5'd20, $urandom & 32'hffff_fffe);	// even base
		issue(j_type(21'($urandom) & ~21'd1, 5'd1));
		issue(j_type(21'($urandom) & ~21'd1, 5'd0));
		issue(i_type(12'($urandom) | 12'd1, 5'd20, 3'd0, 5'd5, rv_pkg::OPC_JALR));	// odd sum
		issue(i_type(12'($urandom), 5'd20, 3'd0, 5'd0, rv_pkg::OPC_JALR));
		issue(r_type(7'd0, 5'd5, 5'd1, 3'd0, 5'd22, rv_pkg::OPC_OP));	// reads both links
		finish_test("jump");
	endtask

	task automatic test_no_write();
		issue(i_type(12'h010, 5'd2, 3'd2, 5'd3, rv_pkg::OPC_LOAD));
		issue(r_type(7'd0, 5'd4, 5'd2, 3'd2, 5'd4, rv_pkg::OPC_STORE));
		issue(i_type(12'h0ff, 5'd0, 3'd0, 5'd4, rv_pkg::OPC_FENCE));
		issue(32'h0000_0073);	// ecall
		issue(r_type(7'd0, 5'd0, 5'd3, 3'd0, 5'd23, rv_pkg::OPC_OP));
		issue(r_type(7'd0, 5'd0, 5'd4, 3'd0, 5'd24, rv_pkg::OPC_OP));
		finish_test("no_write");
	endtask

	initial begin
		void'($urandom(64273));
		rst        = 1'b1;
		inst_valid = 1'b0;
		inst       = '0;
		pc         = '0;
		edge_cnt   = '0;
		err_cnt    = 0;
		err_mark   = 0;
		chk_cnt    = 0;
		tst_cnt    = 0;
		cur_pc     = $urandom & 32'hffff_fffc;
		for (int i = 0; i < 32; i++) begin
			sh[i] = '0;
		end
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		test_reset();
		test_op_imm();
		test_op_reg();
		test_branch();
		test_jump();
		test_no_write();
		$display("%0d tests, %0d checks, %0d errors", tst_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== execute/alu.sv ====
`timescale 1ns/1ns

module alu #(
	parameter int xlen = rv_pkg::XLEN
) (
	input  rv_pkg::alu_op_t op,
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b,
	output logic [xlen-1:0] y
);

	localparam int shw = $clog2(xlen);	// 5 bits at xlen 32

	logic [shw-1:0] shamt;
	logic           lt_s;
	logic           lt_u;

	assign shamt = b[shw-1:0];
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		case (op)
			rv_pkg::ALU_ADD : y = a + b;
			rv_pkg::ALU_SUB : y = a - b;
			rv_pkg::ALU_SLL : y = a << shamt;
			rv_pkg::ALU_SLT : y = {{(xlen-1){1'b0}}, lt_s};
			rv_pkg::ALU_SLTU: y = {{(xlen-1){1'b0}}, lt_u};
			rv_pkg::ALU_XOR : y = a ^ b;
			rv_pkg::ALU_SRL : y = a >> shamt;
			rv_pkg::ALU_SRA : y = $unsigned($signed(a) >>> shamt);
			rv_pkg::ALU_OR  : y = a | b;
			rv_pkg::ALU_AND : y = a & b;
			rv_pkg::ALU_PC  : y = a + b;	// auipc and link address
			default         : y = '0;
		endcase
	end

endmodule

// ==== execute/exec_stage.sv ====
`timescale 1ns/1ns

module exec_stage #(
	parameter int xlen = rv_pkg::XLEN
) (
	input  logic            clk,
	input  logic            rst,
	dec_ex_if.dst           dec,
	output logic [4:0]      raddr1,
	output logic [4:0]      raddr2,
	input  logic [xlen-1:0] rdata1,
	input  logic [xlen-1:0] rdata2,
	ex_wb_if.src            exr
);

	logic [xlen-1:0] rs1_val;
	logic [xlen-1:0] rs2_val;
	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] alu_y;
	logic [xlen-1:0] tgt_base;
	logic [xlen-1:0] tgt_sum;
	logic            taken;
	logic            wb_en;

	assign raddr1 = dec.rs1;
	assign raddr2 = dec.rs2;

	// previous result is one edge short of the register file
	assign rs1_val = (exr.valid && exr.wb_en && exr.rd == dec.rs1) ? exr.data : rdata1;
	assign rs2_val = (exr.valid && exr.wb_en && exr.rd == dec.rs2) ? exr.data : rdata2;

	always_comb begin
		case (dec.src_sel)
			rv_pkg::SRC_RS1_RS2: begin op_a = rs1_val; op_b = rs2_val; end
			rv_pkg::SRC_PC_IMM : begin op_a = dec.pc;  op_b = dec.imm; end
			rv_pkg::SRC_PC_4   : begin op_a = dec.pc;  op_b = xlen'(4); end
			default            : begin op_a = rs1_val; op_b = dec.imm; end
		endcase
	end

	alu #(.xlen(xlen)) u_alu (
		.op (dec.alu_op),
		.a  (op_a),
		.b  (op_b),
		.y  (alu_y)
	);

	always_comb begin
		case (dec.inst_class)
			rv_pkg::CLS_BRANCH: begin
				case (dec.funct3)
					3'b000 : taken = (alu_y == '0);	// beq
					3'b001 : taken = (alu_y != '0);	// bne
					3'b100 : taken = alu_y[0];	// blt
					3'b101 : taken = ~alu_y[0];	// bge
					3'b110 : taken = alu_y[0];	// bltu
					3'b111 : taken = ~alu_y[0];	// bgeu
					default: taken = 1'b0;
				endcase
			end
			rv_pkg::CLS_JAL, rv_pkg::CLS_JALR: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign tgt_base = (dec.inst_class == rv_pkg::CLS_JALR) ? rs1_val : dec.pc;
	assign tgt_sum  = tgt_base + dec.imm;

	assign wb_en = (dec.inst_class == rv_pkg::CLS_ALU ||
	                dec.inst_class == rv_pkg::CLS_JAL ||
	                dec.inst_class == rv_pkg::CLS_JALR) && dec.rd != 5'd0;

	always_ff @(posedge clk) begin
		if (rst) begin
			exr.valid <= 1'b0;
		end else begin
			exr.valid <= dec.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (dec.valid) begin
			exr.wb_en     <= wb_en;
			exr.rd        <= dec.rd;
			exr.data      <= alu_y;
			exr.br_taken  <= taken;
			exr.br_target <= {tgt_sum[xlen-1:1], 1'b0};	// bit 0 clear for jalr
		end
	end

endmodule

// ==== hdl/int_exec_unit.sv ====
`timescale 1ns/1ns

module int_exec_unit #(
	parameter int xlen = rv_pkg::XLEN
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            inst_valid,
	input  logic [31:0]     inst,
	input  logic [xlen-1:0] pc,
	output logic            wb_valid,
	output logic [4:0]      wb_rd,
	output logic [xlen-1:0] wb_data,
	output logic            br_taken,
	output logic [xlen-1:0] br_target
);

	logic [4:0]      raddr1;
	logic [4:0]      raddr2;
	logic [xlen-1:0] rdata1;
	logic [xlen-1:0] rdata2;
	logic            we;
	logic [4:0]      waddr;
	logic [xlen-1:0] wdata;

	dec_ex_if #(.xlen(xlen)) dec_ex ();
	ex_wb_if  #(.xlen(xlen)) ex_wb ();

	inst_decode #(.xlen(xlen)) u_inst_decode (
		.clk        (clk),
		.rst        (rst),
		.inst_valid (inst_valid),
		.inst       (inst),
		.pc         (pc),
		.dec        (dec_ex.src)
	);

	reg_file #(.xlen(xlen)) u_reg_file (
		.clk    (clk),
		.rst    (rst),
		.raddr1 (raddr1),
		.raddr2 (raddr2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.we     (we),
		.waddr  (waddr),
		.wdata  (wdata)
	);

	exec_stage #(.xlen(xlen)) u_exec_stage (
		.clk    (clk),
		.rst    (rst),
		.dec    (dec_ex.dst),
		.raddr1 (raddr1),
		.raddr2 (raddr2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.exr    (ex_wb.src)
	);

	writeback #(.xlen(xlen)) u_writeback (
		.clk       (clk),
		.rst       (rst),
		.exr       (ex_wb.dst),
		.we        (we),
		.waddr     (waddr),
		.wdata     (wdata),
		.wb_valid  (wb_valid),
		.wb_rd     (wb_rd),
		.wb_data   (wb_data),
		.br_taken  (br_taken),
		.br_target (br_target)
	);

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ns

module reg_file #(
	parameter int xlen = rv_pkg::XLEN
) (
	input  logic            clk,
	input  logic            rst,
	input  logic [4:0]      raddr1,
	input  logic [4:0]      raddr2,
	output logic [xlen-1:0] rdata1,
	output logic [xlen-1:0] rdata2,
	input  logic            we,
	input  logic [4:0]      waddr,
	input  logic [xlen-1:0] wdata
);

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != 5'd0) begin	// x0 stays zero
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== hdl/writeback.sv ====
`timescale 1ns/1ns

module writeback #(
	parameter int xlen = rv_pkg::XLEN
) (
	input  logic            clk,
	input  logic            rst,
	ex_wb_if.dst            exr,
	output logic            we,
	output logic [4:0]      waddr,
	output logic [xlen-1:0] wdata,
	output logic            wb_valid,
	output logic [4:0]      wb_rd,
	output logic [xlen-1:0] wb_data,
	output logic            br_taken,
	output logic [xlen-1:0] br_target
);

	assign we    = exr.valid & exr.wb_en;
	assign waddr = exr.rd;
	assign wdata = exr.data;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid  <= 1'b0;
			wb_rd     <= 5'd0;
			wb_data   <= '0;
			br_taken  <= 1'b0;
			br_target <= '0;
		end else begin
			wb_valid  <= exr.valid;
			wb_rd     <= we ? exr.rd : 5'd0;	// zero when nothing written
			wb_data   <= we ? exr.data : '0;
			br_taken  <= exr.valid & exr.br_taken;
			br_target <= (exr.valid && exr.br_taken) ? exr.br_target : '0;
		end
	end

endmodule

// ==== tb.f ====
common/rv_pkg.sv
common/dec_ex_if.sv
common/ex_wb_if.sv
decode/op_select.sv
decode/inst_decode.sv
hdl/reg_file.sv
execute/alu.sv
execute/exec_stage.sv
hdl/writeback.sv
hdl/int_exec_unit.sv
dv/int_exec_sva.sv
dv/tb_int_exec.sv
